// ==== vgen_consts.svh ====
// tiny 64x16 raster for short simulations; VGEN_FETCH_LEAD must match the six-cycle text pipeline
`ifndef VGEN_CONSTS_SVH
`define VGEN_CONSTS_SVH

// horizontal timing in pixels, the line starts with blanking
`define VGEN_H_VISIBLE      64
`define VGEN_H_FRONT        4
`define VGEN_H_SYNC         8
`define VGEN_H_BACK         12
`define VGEN_H_TOTAL        (`VGEN_H_VISIBLE + `VGEN_H_FRONT + `VGEN_H_SYNC + `VGEN_H_BACK)

// vertical timing in lines, the frame starts with visible lines
`define VGEN_V_VISIBLE      16
`define VGEN_V_FRONT        2
`define VGEN_V_SYNC         2
`define VGEN_V_BACK         4
`define VGEN_V_TOTAL        (`VGEN_V_VISIBLE + `VGEN_V_FRONT + `VGEN_V_SYNC + `VGEN_V_BACK)

`define VGEN_H_SYNC_POL     1'b0        // active low hsync
`define VGEN_V_SYNC_POL     1'b0        // active low vsync

`define VGEN_FETCH_LEAD     6           // tile read to pixel out latency

// register numbers
`define VGEN_REG_DISPSTART  4'd0
`define VGEN_REG_DISPWIDTH  4'd1
`define VGEN_REG_FONTCTRL   4'd3
`define VGEN_REG_WIDTH      4'd8        // read only
`define VGEN_REG_HEIGHT     4'd9        // read only
`define VGEN_REG_SCANLINE   4'd11       // read only

// register reset values
`define VGEN_RST_LINE_WIDTH  16'd8      // one tile row of 64 pixels
`define VGEN_RST_FONT_HEIGHT 4'd7       // 8-row cells

`endif

// ==== vgen_timing_pkg.sv ====
// raster types only; the counter width allows modes up to 2047 pixels or lines
package vgen_timing_pkg;

    typedef logic [10:0] raster_cnt_t;      // horizontal or vertical count

    // states run in this order, visible wraps back to pre_sync
    typedef enum logic [1:0] {
        pre_sync  = 2'b00,                  // front porch
        sync      = 2'b01,                  // sync pulse
        post_sync = 2'b10,                  // back porch
        visible   = 2'b11
    } sync_state_t;

endpackage

// ==== vgen_plane_pkg.sv ====
// memory and register types of the text plane; font memory holds 4096 words
package vgen_plane_pkg;

    typedef logic [15:0] vram_addr_t;       // vram word address
    typedef logic [15:0] mem_word_t;        // vram, font or register word
    typedef logic [11:0] font_addr_t;       // font memory word address
    typedef logic [3:0]  tile_row_t;        // line within a tile cell
    typedef logic [3:0]  pal_index_t;       // palette index
    typedef logic [3:0]  reg_num_t;         // register number
    typedef logic [1:0]  font_bank_t;       // font bank, bit 0 ignored for tall cells

endpackage

// ==== sync_gen.sv ====
// raster for the 64x16 mode; every output lags the counters by one clock, enable acts per frame
`timescale 1ns/1ns
`include "vgen_consts.svh"

module sync_gen (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         enable_i,       // latched at frame end
    output logic                         hsync_o,
    output logic                         vsync_o,
    output logic                         dv_de_o,        // visible pixel
    output logic                         line_end_o,     // last cycle of each line
    output logic                         frame_end_o,    // last cycle of the frame
    output logic                         fetch_start_o,  // first cycle of fetch window
    output logic                         fetch_active_o, // fetch window open
    output vgen_timing_pkg::raster_cnt_t v_count_o,      // current scanline
    output logic                         h_blank_o,
    output logic                         v_blank_o
);
    localparam int H_SYNC_BEGIN = `VGEN_H_FRONT;
    localparam int H_OFFSCREEN  = H_SYNC_BEGIN + `VGEN_H_SYNC + `VGEN_H_BACK;
    localparam int V_SYNC_BEGIN = `VGEN_V_VISIBLE + `VGEN_V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_BEGIN + `VGEN_V_SYNC;
    localparam int FETCH_BEGIN  = H_OFFSCREEN - `VGEN_FETCH_LEAD;     // ahead of pixel 0
    localparam int FETCH_END    = FETCH_BEGIN + `VGEN_H_VISIBLE - 1;  // 8 tiles of 8 cycles

    vgen_timing_pkg::sync_state_t h_state;
    vgen_timing_pkg::sync_state_t h_state_next;
    vgen_timing_pkg::sync_state_t v_state;
    vgen_timing_pkg::sync_state_t v_state_next;
    vgen_timing_pkg::raster_cnt_t h_count;
    vgen_timing_pkg::raster_cnt_t v_count;
    int   h_limit;                                  // last count of current h state
    int   v_limit;                                  // last line of current v state
    logic h_at_limit;
    logic v_at_limit;
    logic h_last;                                   // last pixel of the line
    logic v_last;                                   // last pixel of the frame
    logic vg_enable;                                // frame enable
    logic in_fetch;

    always_comb begin
        case (h_state)
            vgen_timing_pkg::pre_sync:  h_limit = H_SYNC_BEGIN - 1;
            vgen_timing_pkg::sync:      h_limit = H_SYNC_BEGIN + `VGEN_H_SYNC - 1;
            vgen_timing_pkg::post_sync: h_limit = H_OFFSCREEN - 1;
            default:                    h_limit = `VGEN_H_TOTAL - 1;    // visible
        endcase
        case (v_state)
            vgen_timing_pkg::pre_sync:  v_limit = V_SYNC_BEGIN - 1;
            vgen_timing_pkg::sync:      v_limit = V_SYNC_END - 1;
            vgen_timing_pkg::post_sync: v_limit = `VGEN_V_TOTAL - 1;
            default:                    v_limit = `VGEN_V_VISIBLE - 1;  // visible
        endcase
    end

    always_comb begin
        h_at_limit   = (int'(h_count) == h_limit);
        v_at_limit   = (int'(v_count) == v_limit);
        h_last       = h_at_limit && (h_state == vgen_timing_pkg::visible);
        v_last       = h_last && v_at_limit && (v_state == vgen_timing_pkg::post_sync);
        h_state_next = h_at_limit ? vgen_timing_pkg::sync_state_t'(h_state + 2'd1) : h_state;
        v_state_next = (h_last && v_at_limit) ?
                       vgen_timing_pkg::sync_state_t'(v_state + 2'd1) : v_state;
        in_fetch     = vg_enable && (v_state == vgen_timing_pkg::visible) &&
                       (int'(h_count) >= FETCH_BEGIN) && (int'(h_count) <= FETCH_END);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state        <= vgen_timing_pkg::pre_sync;    // line 0, column 0
            v_state        <= vgen_timing_pkg::visible;
            h_count        <= '0;
            v_count        <= '0;
            vg_enable      <= 1'b1;
            hsync_o        <= ~`VGEN_H_SYNC_POL;
            vsync_o        <= ~`VGEN_V_SYNC_POL;
            dv_de_o        <= 1'b0;
            line_end_o     <= 1'b0;
            frame_end_o    <= 1'b0;
            fetch_start_o  <= 1'b0;
            fetch_active_o <= 1'b0;
            v_count_o      <= '0;
            h_blank_o      <= 1'b0;
            v_blank_o      <= 1'b0;
        end else begin
            h_state <= h_state_next;
            v_state <= v_state_next;
            h_count <= h_last ? '0 : h_count + 1'b1;
            if (h_last) begin
                v_count <= v_last ? '0 : v_count + 1'b1;    // wraps at frame end
            end
            if (v_last) begin
                vg_enable <= enable_i;                      // holds for the whole next frame
            end
            hsync_o        <= (h_state == vgen_timing_pkg::sync) ? `VGEN_H_SYNC_POL
                                                                 : ~`VGEN_H_SYNC_POL;
            vsync_o        <= (v_state == vgen_timing_pkg::sync) ? `VGEN_V_SYNC_POL
                                                                 : ~`VGEN_V_SYNC_POL;
            dv_de_o        <= vg_enable && (h_state == vgen_timing_pkg::visible) &&
                              (v_state == vgen_timing_pkg::visible);
            line_end_o     <= h_last;
            frame_end_o    <= v_last;
            fetch_start_o  <= in_fetch && (int'(h_count) == FETCH_BEGIN);
            fetch_active_o <= in_fetch;
            v_count_o      <= v_count;
            h_blank_o      <= (h_state != vgen_timing_pkg::visible);
            v_blank_o      <= (v_state != vgen_timing_pkg::visible);
        end
    end

endmodule

// ==== vgen_regs.sv ====
// configuration registers; read data lags reg_num_i by one clock, writes land at the next edge
`timescale 1ns/1ns
`include "vgen_consts.svh"

module vgen_regs (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         reg_wr_i,       // write strobe
    input  vgen_plane_pkg::reg_num_t     reg_num_i,
    input  vgen_plane_pkg::mem_word_t    reg_data_i,
    output vgen_plane_pkg::mem_word_t    reg_data_o,     // registered read data
    input  vgen_timing_pkg::raster_cnt_t v_count_i,
    input  logic                         h_blank_i,
    input  logic                         v_blank_i,
    output vgen_plane_pkg::vram_addr_t   start_addr_o,   // text start, used at frame end
    output vgen_plane_pkg::vram_addr_t   line_width_o,   // words per tile row
    output vgen_plane_pkg::font_bank_t   font_bank_o,
    output vgen_plane_pkg::tile_row_t    font_height_o   // cell height minus one
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            start_addr_o  <= '0;
            line_width_o  <= `VGEN_RST_LINE_WIDTH;
            font_bank_o   <= '0;
            font_height_o <= `VGEN_RST_FONT_HEIGHT;
            reg_data_o    <= '0;
        end else begin
            if (reg_wr_i) begin
                case (reg_num_i)
                    `VGEN_REG_DISPSTART: start_addr_o <= reg_data_i;
                    `VGEN_REG_DISPWIDTH: line_width_o <= reg_data_i;
                    `VGEN_REG_FONTCTRL: begin
                        font_bank_o   <= reg_data_i[11:10];
                        font_height_o <= reg_data_i[3:0];
                    end
                    default: begin
                    end                                     // read only or unused
                endcase
            end

            case (reg_num_i)
                `VGEN_REG_DISPSTART: reg_data_o <= start_addr_o;
                `VGEN_REG_DISPWIDTH: reg_data_o <= line_width_o;
                `VGEN_REG_FONTCTRL:  reg_data_o <= {4'h0, font_bank_o, 6'h00, font_height_o};
                `VGEN_REG_WIDTH:     reg_data_o <= vgen_plane_pkg::mem_word_t'(`VGEN_H_VISIBLE);
                `VGEN_REG_HEIGHT:    reg_data_o <= vgen_plane_pkg::mem_word_t'(`VGEN_V_VISIBLE);
                `VGEN_REG_SCANLINE:  reg_data_o <= {v_blank_i, h_blank_i, 3'b000, v_count_i};
                default:             reg_data_o <= '0;
            endcase
        end
    end

endmodule

// ==== text_plane.sv ====
// text fetch; memories must answer one clock after select, reset must last at least two clocks
`timescale 1ns/1ns

module text_plane (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       fetch_start_i,   // tile cycle 0 of the first tile
    input  logic                       fetch_active_i,
    input  logic                       line_end_i,
    input  logic                       frame_end_i,
    input  vgen_plane_pkg::vram_addr_t start_addr_i,
    input  vgen_plane_pkg::vram_addr_t line_width_i,
    input  vgen_plane_pkg::font_bank_t font_bank_i,
    input  vgen_plane_pkg::tile_row_t  font_height_i,
    input  vgen_plane_pkg::mem_word_t  vram_data_i,
    input  vgen_plane_pkg::mem_word_t  fontram_data_i,
    output logic                       vram_sel_o,
    output vgen_plane_pkg::vram_addr_t vram_addr_o,
    output logic                       fontram_sel_o,
    output vgen_plane_pkg::font_addr_t fontram_addr_o,
    output vgen_plane_pkg::pal_index_t pal_index_o
);
    vgen_plane_pkg::vram_addr_t addr_q;             // next tile word
    vgen_plane_pkg::vram_addr_t line_addr_q;        // first tile word of the row
    vgen_plane_pkg::tile_row_t  row_q;              // line within the cell
    vgen_plane_pkg::tile_row_t  font_height_q;
    vgen_plane_pkg::font_bank_t font_bank_q;
    vgen_plane_pkg::font_addr_t font_addr;
    logic [2:0]                 tile_x_q;           // cycle within the tile
    logic [2:0]                 phase;
    logic [7:0]                 attr_save_q;        // colours of the tile being fetched
    logic [7:0]                 attr_q;             // colours of the tile on screen
    logic [7:0]                 shift_q;            // font bits, msb is the current pixel

    always_comb begin
        phase = fetch_start_i ? 3'd0 : tile_x_q;
        if (font_height_q[3]) begin                 // tall cells use half the banks
            font_addr = {font_bank_q[1], vram_data_i[7:0], row_q[3:1]};
        end else begin
            font_addr = {font_bank_q, vram_data_i[7:0], row_q[2:1]};
        end
    end

    // font settings change only between frames
    always_ff @(posedge clk) begin
        if (reset_i || frame_end_i) begin
            font_bank_q   <= font_bank_i;
            font_height_q <= font_height_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_active_i && phase == 3'd0) begin
            vram_addr_o <= addr_q;
        end
        if (fetch_active_i && phase == 3'd2) begin
            attr_save_q    <= vram_data_i[15:8];    // tile word arrived
            fontram_addr_o <= font_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            tile_x_q      <= '0;
            vram_sel_o    <= 1'b0;
            fontram_sel_o <= 1'b0;
            pal_index_o   <= '0;
            shift_q       <= '0;
            attr_q        <= '0;
            row_q         <= '0;
            addr_q        <= '0;
            line_addr_q   <= '0;
        end else begin
            vram_sel_o    <= 1'b0;
            fontram_sel_o <= 1'b0;
            shift_q       <= {shift_q[6:0], 1'b0};
            pal_index_o   <= shift_q[7] ? attr_q[3:0] : attr_q[7:4];    // fg 11:8, bg 15:12

            if (fetch_active_i) begin
                tile_x_q <= phase + 3'd1;
                case (phase)
                    3'd0: begin
                        vram_sel_o <= 1'b1;                 // tile word read
                        addr_q     <= addr_q + 1'b1;
                    end
                    3'd2: fontram_sel_o <= 1'b1;            // font read for that tile
                    3'd4: begin
                        shift_q <= row_q[0] ? fontram_data_i[7:0] : fontram_data_i[15:8];
                        attr_q  <= attr_save_q;
                    end
                    default: begin
                    end
                endcase
            end

            if (frame_end_i) begin
                addr_q      <= start_addr_i;
                line_addr_q <= start_addr_i;
                row_q       <= '0;
            end else if (line_end_i) begin
                if (row_q == font_height_q) begin           // last row of the cell
                    row_q       <= '0;
                    line_addr_q <= line_addr_q + line_width_i;
                    addr_q      <= line_addr_q + line_width_i;
                end else begin
                    row_q  <= row_q + 1'b1;
                    addr_q <= line_addr_q;                  // same tile row again
                end
            end
        end
    end

endmodule

// ==== video_gen.sv ====
// text-mode video generator top; memories are external with a fixed one-clock read latency
`timescale 1ns/1ns

module video_gen (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       enable_i,        // takes effect at frame end
    input  logic                       reg_wr_i,
    input  vgen_plane_pkg::reg_num_t   reg_num_i,
    input  vgen_plane_pkg::mem_word_t  reg_data_i,
    output vgen_plane_pkg::mem_word_t  reg_data_o,
    input  vgen_plane_pkg::mem_word_t  vram_data_i,
    output logic                       vram_sel_o,
    output vgen_plane_pkg::vram_addr_t vram_addr_o,
    input  vgen_plane_pkg::mem_word_t  fontram_data_i,
    output logic                       fontram_sel_o,
    output vgen_plane_pkg::font_addr_t fontram_addr_o,
    output vgen_plane_pkg::pal_index_t pal_index_o,
    output logic                       hsync_o,
    output logic                       vsync_o,
    output logic                       dv_de_o
);
    logic                         line_end;
    logic                         frame_end;
    logic                         fetch_start;
    logic                         fetch_active;
    vgen_timing_pkg::raster_cnt_t v_count;
    logic                         h_blank;
    logic                         v_blank;
    vgen_plane_pkg::vram_addr_t   start_addr;
    vgen_plane_pkg::vram_addr_t   line_width;
    vgen_plane_pkg::font_bank_t   font_bank;
    vgen_plane_pkg::tile_row_t    font_height;

    sync_gen u_sync_gen (
        .clk            (clk),
        .reset_i        (reset_i),
        .enable_i       (enable_i),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .dv_de_o        (dv_de_o),
        .line_end_o     (line_end),
        .frame_end_o    (frame_end),
        .fetch_start_o  (fetch_start),
        .fetch_active_o (fetch_active),
        .v_count_o      (v_count),
        .h_blank_o      (h_blank),
        .v_blank_o      (v_blank)
    );

    vgen_regs u_vgen_regs (
        .clk           (clk),
        .reset_i       (reset_i),
        .reg_wr_i      (reg_wr_i),
        .reg_num_i     (reg_num_i),
        .reg_data_i    (reg_data_i),
        .reg_data_o    (reg_data_o),
        .v_count_i     (v_count),
        .h_blank_i     (h_blank),
        .v_blank_i     (v_blank),
        .start_addr_o  (start_addr),
        .line_width_o  (line_width),
        .font_bank_o   (font_bank),
        .font_height_o (font_height)
    );

    text_plane u_text_plane (
        .clk            (clk),
        .reset_i        (reset_i),
        .fetch_start_i  (fetch_start),
        .fetch_active_i (fetch_active),
        .line_end_i     (line_end),
        .frame_end_i    (frame_end),
        .start_addr_i   (start_addr),
        .line_width_i   (line_width),
        .font_bank_i    (font_bank),
        .font_height_i  (font_height),
        .vram_data_i    (vram_data_i),
        .fontram_data_i (fontram_data_i),
        .vram_sel_o     (vram_sel_o),
        .vram_addr_o    (vram_addr_o),
        .fontram_sel_o  (fontram_sel_o),
        .fontram_addr_o (fontram_addr_o),
        .pal_index_o    (pal_index_o)
    );

endmodule

// ==== video_gen_properties.sv ====
// bound into video_gen; assumes active-level sync polarity from the consts header
`timescale 1ns/1ns
`include "vgen_consts.svh"

module video_gen_properties (
    input logic                         clk,
    input logic                         reset_i,
    input logic                         hsync_i,
    input logic                         dv_de_i,
    input vgen_timing_pkg::raster_cnt_t v_count_i,
    input logic                         vram_sel_i,
    input logic                         fontram_sel_i
);
    int sync_run;                                   // active hsync cycles so far
    int line_pos;                                   // cycles since the hsync pulse ended

    always @(posedge clk) begin
        if (reset_i || hsync_i != `VGEN_H_SYNC_POL) begin
            sync_run <= 0;
        end else begin
            sync_run <= sync_run + 1;
        end
        if (reset_i || hsync_i == `VGEN_H_SYNC_POL) begin
            line_pos <= 0;
        end else begin
            line_pos <= line_pos + 1;
        end
    end

    // pulse ends after exactly the sync width
    hsync_width: assert property (@(posedge clk) disable iff (reset_i)
        (hsync_i != `VGEN_H_SYNC_POL && $past(hsync_i) == `VGEN_H_SYNC_POL)
        |-> sync_run == `VGEN_H_SYNC)
        else $error("hsync pulse width is not %0d cycles", `VGEN_H_SYNC);

    font_after_tile: assert property (@(posedge clk) disable iff (reset_i)
        fontram_sel_i |-> $past(vram_sel_i, 2))  // font read follows its tile read
        else $error("font select without tile select two cycles earlier");

    // visible pixels sit after the back porch and on the first lines of the frame
    de_in_visible: assert property (@(posedge clk) disable iff (reset_i)
        dv_de_i |-> (line_pos >= `VGEN_H_BACK) &&
                    (line_pos < `VGEN_H_BACK + `VGEN_H_VISIBLE) &&
                    (int'(v_count_i) < `VGEN_V_VISIBLE))
        else $error("display enable outside the visible area");

endmodule

bind video_gen video_gen_properties u_video_gen_properties (
    .clk           (clk),
    .reset_i       (reset_i),
    .hsync_i       (hsync_o),
    .dv_de_i       (dv_de_o),
    .v_count_i     (v_count),
    .vram_sel_i    (vram_sel_o),
    .fontram_sel_i (fontram_sel_o)
);

// ==== video_gen_tb.sv ====
// self-checking testbench; memories answer one clock after select and the run stops at 12 frames
`timescale 1ns/1ns
`include "vgen_consts.svh"

module video_gen_tb;
    localparam int LINE_CYCLES  = `VGEN_H_TOTAL;
    localparam int FRAME_CYCLES = LINE_CYCLES * `VGEN_V_TOTAL;
    localparam int TIMEOUT      = 12 * FRAME_CYCLES;            // about five frames needed
    localparam int FRAME_PIXELS = `VGEN_H_VISIBLE * `VGEN_V_VISIBLE;

    logic                       clk;
    logic                       reset_i;
    logic                       enable_i;
    logic                       reg_wr_i;
    vgen_plane_pkg::reg_num_t   reg_num_i;
    vgen_plane_pkg::mem_word_t  reg_data_i;
    vgen_plane_pkg::mem_word_t  reg_data_o;
    vgen_plane_pkg::mem_word_t  vram_data_i;
    logic                       vram_sel_o;
    vgen_plane_pkg::vram_addr_t vram_addr_o;
    vgen_plane_pkg::mem_word_t  fontram_data_i;
    logic                       fontram_sel_o;
    vgen_plane_pkg::font_addr_t fontram_addr_o;
    vgen_plane_pkg::pal_index_t pal_index_o;
    logic                       hsync_o;
    logic                       vsync_o;
    logic                       dv_de_o;

    vgen_plane_pkg::mem_word_t  vram [0:65535];                 // full 16-bit address space
    vgen_plane_pkg::mem_word_t  font [0:4095];
    logic [31:0]                lcg_state;
    vgen_plane_pkg::vram_addr_t ref_start;                      // expected frame settings
    vgen_plane_pkg::vram_addr_t ref_width;
    vgen_plane_pkg::font_bank_t ref_bank;
    vgen_plane_pkg::tile_row_t  ref_height;
    int   err_cnt;
    int   check_cnt;
    int   cycle_cnt;
    int   pix_checked;
    int   col;
    int   line_idx;
    int   last_de_run;
    int   de_bad_runs;
    int   last_frame_lines;
    int   hs_cnt;
    int   last_hs_period;
    int   vs_cnt;
    int   last_vs_cycles;
    int   de_seen;
    int   sel_seen;
    logic check_en;
    logic hs_q;
    logic vs_q;
    logic de_q;

    video_gen u_video_gen (
        .clk(clk), .reset_i(reset_i), .enable_i(enable_i),
        .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i), .reg_data_i(reg_data_i),
        .reg_data_o(reg_data_o), .vram_data_i(vram_data_i), .vram_sel_o(vram_sel_o),
        .vram_addr_o(vram_addr_o), .fontram_data_i(fontram_data_i),
        .fontram_sel_o(fontram_sel_o), .fontram_addr_o(fontram_addr_o),
        .pal_index_o(pal_index_o), .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
    );

    always #50 clk = ~clk;                                      // 100 ns period

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // expected palette index for visible pixel x of line y
    function automatic vgen_plane_pkg::pal_index_t ref_pixel(input int x, input int y);
        int                         rows;
        vgen_plane_pkg::tile_row_t  row;
        vgen_plane_pkg::vram_addr_t taddr;
        vgen_plane_pkg::mem_word_t  tword;
        vgen_plane_pkg::mem_word_t  fword;
        vgen_plane_pkg::font_addr_t faddr;
        logic [7:0]                 bits;
        rows  = int'(ref_height) + 1;
        row   = vgen_plane_pkg::tile_row_t'(y % rows);
        taddr = ref_start + 16'((y / rows) * int'(ref_width)) + 16'(x / 8);
        tword = vram[taddr];
        if (ref_height >= 4'd8) begin
            faddr = {ref_bank[1], tword[7:0], row[3:1]};      // tall cells use two banks
        end else begin
            faddr = {ref_bank, tword[7:0], row[2:1]};
        end
        fword = font[faddr];
        bits  = row[0] ? fword[7:0] : fword[15:8];            // odd row in low byte
        return bits[3'(7 - (x % 8))] ? tword[11:8] : tword[15:12];
    endfunction

    task automatic check_val(input int got, input int exp, input string what);
        check_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("ERR %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic test_done(input string name, input int errs_before);
        if (err_cnt == errs_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, err_cnt - errs_before);
    endtask

    task automatic reg_write(input vgen_plane_pkg::reg_num_t num,
                             input vgen_plane_pkg::mem_word_t data);
        @(posedge clk);
        reg_wr_i   <= 1'b1;
        reg_num_i  <= num;
        reg_data_i <= data;
        @(posedge clk);
        reg_wr_i   <= 1'b0;
    endtask

    task automatic reg_read(input vgen_plane_pkg::reg_num_t num,
                            output vgen_plane_pkg::mem_word_t data);
        @(posedge clk);
        reg_num_i <= num;
        repeat (2) @(posedge clk);                              // one cycle read latency
        data = reg_data_o;
    endtask

    task automatic wait_vsync_end();
        while (vsync_o != `VGEN_V_SYNC_POL) @(posedge clk);
        while (vsync_o == `VGEN_V_SYNC_POL) @(posedge clk);      // first line after the pulse
        @(posedge clk);                                         // monitor has logged the pulse end
    endtask

    task automatic check_next_frame(input string what);
        int base;
        base     = pix_checked;
        check_en = 1'b1;
        wait_vsync_end();
        check_en = 1'b0;
        check_val(pix_checked - base, FRAME_PIXELS, {what, " pixel count"});
    endtask

    // memory models with one clock latency
    always @(posedge clk) begin
        if (vram_sel_o) vram_data_i <= vram[vram_addr_o];
        if (fontram_sel_o) fontram_data_i <= font[fontram_addr_o];
    end

    // raster monitor and pixel comparison
    always @(posedge clk) begin
        if (reset_i) begin
            col         = 0;
            line_idx    = 0;
            de_bad_runs = 0;
            hs_cnt      = 0;
            vs_cnt      = 0;
            hs_q        = ~`VGEN_H_SYNC_POL;
            vs_q        = ~`VGEN_V_SYNC_POL;
            de_q        = 1'b0;
        end else begin
            if (dv_de_o) begin
                if (check_en) begin
                    check_val(int'(pal_index_o), int'(ref_pixel(col, line_idx)),
                              $sformatf("pixel x%0d y%0d", col, line_idx));
                    pix_checked++;
                end
                col++;
                de_seen++;
            end else if (de_q) begin                            // end of a visible line
                last_de_run = col;
                if (col != `VGEN_H_VISIBLE) de_bad_runs++;
                col = 0;
                line_idx++;
            end
            if (vram_sel_o || fontram_sel_o) sel_seen++;
            if (vsync_o == `VGEN_V_SYNC_POL && vs_q != `VGEN_V_SYNC_POL) begin
                last_frame_lines = line_idx;
                line_idx = 0;
            end
            if (vsync_o == `VGEN_V_SYNC_POL) vs_cnt++;
            else if (vs_q == `VGEN_V_SYNC_POL) begin
                last_vs_cycles = vs_cnt;
                vs_cnt = 0;
            end
            if (hsync_o == `VGEN_H_SYNC_POL && hs_q != `VGEN_H_SYNC_POL) begin
                last_hs_period = hs_cnt;                        // leading edge to leading edge
                hs_cnt = 0;
            end
            hs_cnt++;
            hs_q = hsync_o;
            vs_q = vsync_o;
            de_q = dv_de_o;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        vgen_plane_pkg::mem_word_t rd;
        int errs0;
        logic [31:0] rnd;
        clk              = 1'b0;
        reset_i          = 1'b1;
        enable_i         = 1'b1;
        reg_wr_i         = 1'b0;
        reg_num_i        = '0;
        reg_data_i       = '0;
        vram_data_i      = '0;
        fontram_data_i   = '0;
        err_cnt          = 0;
        check_cnt        = 0;
        cycle_cnt        = 0;
        pix_checked      = 0;
        check_en         = 1'b0;
        de_seen          = 0;
        sel_seen         = 0;
        last_de_run      = 0;
        last_frame_lines = 0;
        last_hs_period   = 0;
        last_vs_cycles   = 0;
        lcg_state        = 32'd13377;
        for (int i = 0; i < 65536; i++) begin
            rnd     = lcg_next();
            vram[i] = rnd[30:15];
        end
        for (int i = 0; i < 4096; i++) begin
            rnd     = lcg_next();
            font[i] = rnd[30:15];
        end
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;

        errs0 = err_cnt;                                        // register read-back
        reg_write(`VGEN_REG_DISPSTART, 16'h1234);
        reg_write(`VGEN_REG_DISPWIDTH, 16'h0021);
        reg_write(`VGEN_REG_FONTCTRL, 16'hfc35);
        reg_read(`VGEN_REG_DISPSTART, rd);
        check_val(int'(rd), 'h1234, "DISPSTART read");
        reg_read(`VGEN_REG_DISPWIDTH, rd);
        check_val(int'(rd), 'h0021, "DISPWIDTH read");
        reg_read(`VGEN_REG_FONTCTRL, rd);
        check_val(int'(rd), int'({4'h0, 2'b11, 6'h00, 4'h5}), "FONTCTRL read");
        reg_read(`VGEN_REG_WIDTH, rd);
        check_val(int'(rd), 64, "WIDTH read");
        reg_read(`VGEN_REG_HEIGHT, rd);
        check_val(int'(rd), 16, "HEIGHT read");
        reg_read(4'd5, rd);                                     // unused slot
        check_val(int'(rd), 0, "unused register read");
        test_done("register read-back", errs0);

        ref_start  = 16'h0100;
        ref_width  = 16'd12;
        ref_bank   = 2'd1;
        ref_height = 4'd7;
        reg_write(`VGEN_REG_DISPSTART, ref_start);              // active from frame 1
        reg_write(`VGEN_REG_DISPWIDTH, ref_width);
        reg_write(`VGEN_REG_FONTCTRL, {4'h0, ref_bank, 6'h00, ref_height});

        errs0 = err_cnt;
        wait_vsync_end();
        check_val(last_de_run, `VGEN_H_VISIBLE, "enable run length");
        check_val(de_bad_runs, 0, "lines with a wrong enable run");
        check_val(last_frame_lines, `VGEN_V_VISIBLE, "visible lines per frame");
        check_val(last_hs_period, LINE_CYCLES, "hsync period");
        check_val(last_vs_cycles, `VGEN_V_SYNC * LINE_CYCLES, "vsync pulse cycles");
        test_done("raster timing", errs0);

        errs0 = err_cnt;
        check_next_frame("8-row");
        test_done("text pixels 8-row cells", errs0);

        errs0 = err_cnt;                                        // still before frame end
        ref_start  = 16'h0400;
        ref_width  = 16'd9;
        ref_bank   = 2'd2;
        ref_height = 4'd15;
        reg_write(`VGEN_REG_DISPSTART, ref_start);
        reg_write(`VGEN_REG_DISPWIDTH, ref_width);
        reg_write(`VGEN_REG_FONTCTRL, {4'h0, ref_bank, 6'h00, ref_height});
        check_next_frame("16-row");
        test_done("text pixels 16-row cells", errs0);

        errs0 = err_cnt;
        @(posedge clk);
        enable_i <= 1'b0;                                       // sampled at next frame end
        de_seen = 0;
        sel_seen = 0;
        wait_vsync_end();
        check_val(de_seen, 0, "enable cycles in disabled frame");
        check_val(sel_seen, 0, "memory selects in disabled frame");
        enable_i <= 1'b1;
        check_next_frame("re-enabled");
        test_done("display disable", errs0);

        errs0 = err_cnt;
        reg_read(`VGEN_REG_SCANLINE, rd);                       // vertical blanking
        check_val(int'(rd[15]), 1, "SCANLINE vblank bit");
        for (int n = 0; n < 3; n++) begin
            while (!dv_de_o) @(posedge clk);
            reg_read(`VGEN_REG_SCANLINE, rd);
            check_val(int'(rd), line_idx, "SCANLINE visible line");
            while (dv_de_o) @(posedge clk);
        end
        test_done("scanline register", errs0);

        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
vgen_timing_pkg.sv
vgen_plane_pkg.sv
sync_gen.sv
vgen_regs.sv
text_plane.sv
video_gen.sv
video_gen_properties.sv
video_gen_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module video_gen_tb \
    -Mdir obj_dir -o vsim > compile.log 2>&1 &&
./obj_dir/vsim > sim.log 2>&1
grep -q "TESTBENCH PASSED" sim.log && echo "simulation passed" ||
    { echo "simulation failed, see compile.log and sim.log"; exit 1; }
